// ==== build.f ====
+incdir+dv
hw/fp_format_pkg.sv
hw/div_status_pkg.sv
hw/mant_div_if.sv
hw/mant_divider.sv
hw/float_div_ctrl.sv
hw/float_div_top.sv
dv/float_div_tb.sv

// ==== dv/float_div_ref.svh ====
// Expected divide result; operands are never NaN or infinity, subnormals read as zero, truncation
`ifndef FLOAT_DIV_REF_SVH
`define FLOAT_DIV_REF_SVH

// ----------------------------------------------------------------------
// Reference model for one division
// ----------------------------------------------------------------------
function automatic void model_divide(
    input  logic [31:0] a_raw,
    input  logic [31:0] b_raw,
    output logic [31:0] want_word,
    output logic [3:0]  want_flags
);
    fp32_word_u  a;
    fp32_word_u  b;
    fp32_word_u  r;
    div_status_s st;
    logic [47:0] num;
    logic [47:0] den;
    logic [47:0] q;
    logic [22:0] frac;
    logic        sign;
    int          e;
    a.raw = a_raw;
    b.raw = b_raw;
    r.raw = '0;
    st    = '0;
    sign  = a.f.sign ^ b.f.sign;
    if (b.f.exp == 8'd0) begin
        // Zero divisor, always +0
        st.div_by_zero = 1'b1;
    end else if (a.f.exp == 8'd0) begin
        r.f.sign       = sign;
        st.zero_result = 1'b1;
    end else begin
        // Significand ratio scaled by 2^24, truncated
        num = {1'b1, a.f.frac, 24'd0};
        den = {24'd0, 1'b1, b.f.frac};
        q   = num / den;
        e   = int'(a.f.exp) - int'(b.f.exp) + FP_EXP_BIAS;
        // Ratio below one needs one more shift
        if (q[24]) begin
            frac = q[23:1];
        end else begin
            frac = q[22:0];
            e    = e - 1;
        end
        if (e > FP_EXP_MAX) begin
            r.raw       = sign ? fp32_inf_neg : fp32_inf_pos;
            st.overflow = 1'b1;
        end else if (e < 1) begin
            r.f.sign       = sign;
            st.underflow   = 1'b1;
            st.zero_result = 1'b1;
        end else begin
            r.f.sign = sign;
            r.f.exp  = 8'(e);
            r.f.frac = frac;
        end
    end
    want_word  = r.raw;
    want_flags = st;
endfunction

`endif

// ==== dv/float_div_tb.sv ====
// Normal, zero and subnormal operands only; one four-phase request at a time, 200 cycle waits
`default_nettype none

module float_div_tb
    import fp_format_pkg::*;
    import div_status_pkg::*;
();

    localparam int DIV_W      = 48;
    localparam int WAIT_LIMIT = 200;

    logic        clk_sys;
    logic        rst_sys_n;
    logic        req;
    logic [31:0] opnd_a;
    logic [31:0] opnd_b;
    logic        ack;
    logic [31:0] quot;
    logic [3:0]  status;
    int          value_errs;
    int          hs_errs;
    int          timeout_errs;

    `include "float_div_ref.svh"

    float_div_top #(
        .DIV_W      (DIV_W)
    ) dut0 (
        .clk_sys    (clk_sys),
        .rst_sys_n  (rst_sys_n),
        .req        (req),
        .opnd_a     (opnd_a),
        .opnd_b     (opnd_b),
        .ack        (ack),
        .quot       (quot),
        .status     (status)
    );

    initial begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;
    end

    // ------------------------------------------------------------------
    // Handshake rules
    // ------------------------------------------------------------------
    // ack only answers a raised req
    assert property (@(posedge clk_sys) disable iff (!rst_sys_n) $rose(ack) |-> $past(req))
    else begin
        hs_errs++;
        $display("[ERROR] %0t: ack rose while req was low", $time);
    end

    // No release before the requester lets go
    assert property (@(posedge clk_sys) disable iff (!rst_sys_n) $fell(ack) |-> !$past(req))
    else begin
        hs_errs++;
        $display("[ERROR] %0t: ack fell while req was high", $time);
    end

    // Result frozen while ack is high
    assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
        (ack && $past(ack)) |-> ($stable(quot) && $stable(status)))
    else begin
        hs_errs++;
        $display("[ERROR] %0t: quot or status changed while ack was high", $time);
    end

    // ------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------
    // Random sign and fraction with exponent field from exp_lo to exp_hi
    function automatic logic [31:0] random_float(input int exp_lo, input int exp_hi);
        return {1'($urandom), 8'($urandom_range(exp_hi, exp_lo)), 23'($urandom)};
    endfunction

    // Full four-phase transfer entered and left just after a rising edge
    task automatic run_request(input logic [31:0] a, input logic [31:0] b, input int hold);
        logic [31:0] want_word;
        logic [3:0]  want_flags;
        int          n;
        model_divide(a, b, want_word, want_flags);
        opnd_a = a;
        opnd_b = b;
        req    = 1'b1;
        n      = 0;
        while (!ack && n < WAIT_LIMIT) begin
            @(posedge clk_sys);
            #1;
            n++;
        end
        if (!ack) begin
            timeout_errs++;
            $display("Timeout: no ack within %0d cycles for a=%h b=%h", WAIT_LIMIT, a, b);
            req = 1'b0;
            return;
        end
        assert (quot === want_word)
        else begin
            value_errs++;
            $display("[ERROR] %0t: quot %h, expected %h (a=%h b=%h)",
                     $time, quot, want_word, a, b);
        end
        assert (status === want_flags)
        else begin
            value_errs++;
            $display("[ERROR] %0t: status %b, expected %b (a=%h b=%h)",
                     $time, status, want_flags, a, b);
        end
        // Back-pressure with req kept high past ack
        repeat (hold) begin
            @(posedge clk_sys);
            #1;
            assert (ack && quot === want_word && status === want_flags)
            else begin
                value_errs++;
                $display("[ERROR] %0t: under back-pressure ack %b quot %h status %b, expected %h %b",
                         $time, ack, quot, status, want_word, want_flags);
            end
        end
        req = 1'b0;
        n   = 0;
        while (ack && n < WAIT_LIMIT) begin
            @(posedge clk_sys);
            #1;
            n++;
        end
        if (ack) begin
            timeout_errs++;
            $display("Timeout: ack still high %0d cycles after req fell", WAIT_LIMIT);
        end
    endtask

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        void'($urandom(32'h6658));
        value_errs   = 0;
        hs_errs      = 0;
        timeout_errs = 0;
        rst_sys_n    = 1'b0;
        req          = 1'b0;
        opnd_a       = '0;
        opnd_b       = '0;
        repeat (4) @(posedge clk_sys);
        #1;
        rst_sys_n = 1'b1;
        // Idle after reset and before any request
        repeat (5) begin
            @(posedge clk_sys);
            #1;
            assert (!ack)
            else begin
                value_errs++;
                $display("[ERROR] %0t: ack high before the first request", $time);
            end
        end
        // Normal operands
        repeat (200) run_request(random_float(64, 190), random_float(64, 190),
                                 $urandom_range(20, 0));
        // Zero or subnormal divisor
        run_request(random_float(1, 254), 32'h0000_0000, 0);
        run_request(random_float(1, 254), 32'h8000_0000, 3);
        repeat (20) run_request(random_float(0, 254), random_float(0, 0), $urandom_range(20, 0));
        // Zero or subnormal dividend
        run_request(32'h0000_0000, random_float(1, 254), 0);
        run_request(32'h8000_0000, random_float(1, 254), 2);
        repeat (20) run_request(random_float(0, 0), random_float(1, 254), $urandom_range(20, 0));
        // Large over small and then small over large
        repeat (20) run_request(random_float(200, 254), random_float(1, 60), $urandom_range(20, 0));
        repeat (20) run_request(random_float(1, 60), random_float(200, 254), $urandom_range(20, 0));
        // Edges of the finite exponent range
        run_request(32'h7F00_0000, 32'h3F80_0000, 1);
        run_request(32'h7F00_0000, 32'h3F00_0000, 0);
        run_request(32'h0080_0000, 32'h3F80_0000, 0);
        run_request(32'h0080_0000, 32'h4000_0000, 1);
        run_request(32'h8080_0000, 32'h3FC0_0000, 0);
        $display("Errors: value %0d, handshake %0d, timeout %0d",
                 value_errs, hs_errs, timeout_errs);
        if (value_errs + hs_errs + timeout_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Overall run limit
    initial begin
        repeat (100000) @(posedge clk_sys);
        $display("Simulation did not finish within the cycle limit");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/div_status_pkg.sv ====
// Flags are not exclusive; an underflow result also carries zero_result
`default_nettype none

package div_status_pkg;

    // ------------------------------------------------------------------
    // Result flags of one division, msb first
    // ------------------------------------------------------------------
    typedef struct packed {
        // Divisor exponent field was zero, result forced to +0
        logic div_by_zero;
        // Exponent above the finite range, result is signed infinity
        logic overflow;
        // Exponent below one, result flushed to signed zero
        logic underflow;
        // Result word is a zero of either sign
        logic zero_result;
    } div_status_s;

endpackage

`default_nettype wire

// ==== hw/float_div_ctrl.sv ====
// Operands stable from req until ack; no NaN or infinity inputs, subnormals read as zero, truncates
`default_nettype none

module float_div_ctrl
    import fp_format_pkg::*;
    import div_status_pkg::*;
#(
    parameter int DIV_W = 48
) (
    input  logic            clk_sys,
    input  logic            rst_sys_n,
    input  logic            req,
    input  fp32_word_u      opnd_a,
    input  fp32_word_u      opnd_b,
    output logic            ack,
    output fp32_word_u      quot,
    output div_status_s     status,
    mant_div_if.controller  div
);

    // Sequencer states
    localparam logic [2:0] ST_IDLE     = 3'd0;
    localparam logic [2:0] ST_UNPACK   = 3'd1;
    localparam logic [2:0] ST_EXPON    = 3'd2;
    localparam logic [2:0] ST_DIV_WAIT = 3'd3;
    localparam logic [2:0] ST_NORM     = 3'd4;
    localparam logic [2:0] ST_CLASS    = 3'd5;
    localparam logic [2:0] ST_DONE     = 3'd6;
    localparam logic [2:0] ST_RELEASE  = 3'd7;

    // Finite exponent range, as signed 10 bit
    localparam logic signed [9:0] EXP_MAX_S = 10'(FP_EXP_MAX);
    localparam logic signed [9:0] EXP_MIN_S = 10'sd1;

    logic [2:0]            state;
    logic [2:0]            state_nxt;
    logic                  start_r;
    logic                  sign_r;
    logic [FP_MANT_W-1:0]  mant_a_r;
    logic [FP_MANT_W-1:0]  mant_b_r;
    logic signed [9:0]     exp_r;
    logic [FP_FRAC_W-1:0]  frac_r;
    fp32_word_u            res_word;
    div_status_s           res_status;

    // ------------------------------------------------------------------
    // State sequence
    // ------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:     if (req) state_nxt = ST_UNPACK;
            // Zero divisor skips the mantissa division
            ST_UNPACK:   state_nxt = (opnd_b.f.exp == '0) ? ST_CLASS : ST_EXPON;
            ST_EXPON:    state_nxt = ST_DIV_WAIT;
            ST_DIV_WAIT: if (div.done) state_nxt = ST_NORM;
            ST_NORM:     state_nxt = ST_CLASS;
            ST_CLASS:    state_nxt = ST_DONE;
            // Hold the result while the requester keeps req high
            ST_DONE:     if (!req) state_nxt = ST_RELEASE;
            ST_RELEASE:  state_nxt = ST_IDLE;
            default:     state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // ------------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------------
    always_ff @(posedge clk_sys) begin
        case (state)
            ST_UNPACK: begin
                sign_r   <= opnd_a.f.sign ^ opnd_b.f.sign;
                // Hidden bit only for a nonzero exponent field
                mant_a_r <= {opnd_a.f.exp != '0, opnd_a.f.frac};
                mant_b_r <= {opnd_b.f.exp != '0, opnd_b.f.frac};
            end
            ST_EXPON: begin
                exp_r <= {2'b00, opnd_a.f.exp} - {2'b00, opnd_b.f.exp} + 10'(FP_EXP_BIAS);
            end
            ST_NORM: begin
                // Ratio of at least one lands the leading one at bit 24
                if (div.quotient[FP_MANT_W]) begin
                    frac_r <= div.quotient[FP_MANT_W-1:1];
                end else begin
                    frac_r <= div.quotient[FP_MANT_W-2:0];
                    exp_r  <= exp_r - 10'sd1;
                end
            end
            default: begin
            end
        endcase
    end

    // Scaled so the quotient keeps 24 fraction bits
    assign div.start    = start_r;
    assign div.dividend = DIV_W'(mant_a_r) << FP_MANT_W;
    assign div.divisor  = DIV_W'(mant_b_r);

    // ------------------------------------------------------------------
    // Result classification, highest priority first
    // ------------------------------------------------------------------
    always_comb begin
        res_word.raw = '0;
        res_status   = '0;
        if (!mant_b_r[FP_MANT_W-1]) begin
            // Always +0, sign dropped
            res_status.div_by_zero = 1'b1;
        end else if (!mant_a_r[FP_MANT_W-1]) begin
            res_word.f.sign        = sign_r;
            res_status.zero_result = 1'b1;
        end else if (exp_r > EXP_MAX_S) begin
            res_word.raw        = sign_r ? fp32_inf_neg : fp32_inf_pos;
            res_status.overflow = 1'b1;
        end else if (exp_r < EXP_MIN_S) begin
            res_word.f.sign        = sign_r;
            res_status.underflow   = 1'b1;
            res_status.zero_result = 1'b1;
        end else begin
            res_word.f.sign = sign_r;
            res_word.f.exp  = exp_r[FP_EXP_W-1:0];
            res_word.f.frac = frac_r;
        end
    end

    // Handshake and result registers
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            start_r <= 1'b0;
            ack     <= 1'b0;
            quot    <= '0;
            status  <= '0;
        end else begin
            start_r <= (state == ST_EXPON);
            if (state == ST_CLASS) begin
                quot   <= res_word;
                status <= res_status;
                ack    <= 1'b1;
            end else if (state == ST_RELEASE) begin
                ack <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/float_div_top.sv ====
// Four-phase req/ack, one division in flight; DIV_W must be at least 2 * 24 for the mantissa path
`default_nettype none

module float_div_top #(
    parameter int DIV_W = 48
) (
    input  logic        clk_sys,
    input  logic        rst_sys_n,
    input  logic        req,
    input  logic [31:0] opnd_a,
    input  logic [31:0] opnd_b,
    output logic        ack,
    output logic [31:0] quot,
    output logic [3:0]  status
);

    // ------------------------------------------------------------------
    // Mantissa divide channel
    // ------------------------------------------------------------------
    mant_div_if #(.DIV_W(DIV_W)) div_bus ();

    // Handshake, exponent path and classification
    float_div_ctrl #(
        .DIV_W      (DIV_W)
    ) u_ctrl (
        .clk_sys    (clk_sys),
        .rst_sys_n  (rst_sys_n),
        .req        (req),
        .opnd_a     (opnd_a),
        .opnd_b     (opnd_b),
        .ack        (ack),
        .quot       (quot),
        .status     (status),
        .div        (div_bus.controller)
    );

    // Shared iterative divider
    mant_divider #(
        .DIV_W      (DIV_W)
    ) u_mant_div (
        .clk_sys    (clk_sys),
        .rst_sys_n  (rst_sys_n),
        .div        (div_bus.divider)
    );

endmodule

`default_nettype wire

// ==== hw/fp_format_pkg.sv ====
// Binary32 layout only; subnormal, NaN and infinity encodings get no types of their own
`default_nettype none

package fp_format_pkg;

    // ------------------------------------------------------------------
    // Field widths of one binary32 word
    // ------------------------------------------------------------------
    localparam int FP_WORD_W = 32;
    localparam int FP_EXP_W  = 8;
    localparam int FP_FRAC_W = 23;
    // Significand including the hidden one
    localparam int FP_MANT_W = FP_FRAC_W + 1;

    // Exponent bias and largest finite biased exponent
    localparam int FP_EXP_BIAS = 127;
    localparam int FP_EXP_MAX  = (1 << FP_EXP_W) - 2;

    // ------------------------------------------------------------------
    // Word views
    // ------------------------------------------------------------------
    // Sign, biased exponent, fraction from msb down
    typedef struct packed {
        logic                 sign;
        logic [FP_EXP_W-1:0]  exp;
        logic [FP_FRAC_W-1:0] frac;
    } fp32_fields_s;

    // Same 32 bits, either as a plain vector or split into fields
    typedef union packed {
        logic [FP_WORD_W-1:0] raw;
        fp32_fields_s         f;
    } fp32_word_u;

    // Signed infinity, all-ones exponent and empty fraction
    localparam logic [FP_WORD_W-1:0] fp32_inf_pos = 32'h7F80_0000;
    localparam logic [FP_WORD_W-1:0] fp32_inf_neg = 32'hFF80_0000;

endpackage

`default_nettype wire

// ==== hw/mant_div_if.sv ====
// One division at a time; start is ignored by a busy divider and quotient holds until next start
`default_nettype none

interface mant_div_if #(
    parameter int DIV_W = 48
);

    // ------------------------------------------------------------------
    // Request side, driven by the controller
    // ------------------------------------------------------------------
    // Single-cycle pulse, operands sampled on it
    logic             start;
    logic [DIV_W-1:0] dividend;
    logic [DIV_W-1:0] divisor;

    // ------------------------------------------------------------------
    // Result side, driven by the divider
    // ------------------------------------------------------------------
    logic [DIV_W-1:0] quotient;
    // Single-cycle pulse, quotient valid from here on
    logic             done;

    modport controller (
        output start, dividend, divisor,
        input  quotient, done
    );

    modport divider (
        input  start, dividend, divisor,
        output quotient, done
    );

endinterface

`default_nettype wire

// ==== hw/mant_divider.sv ====
// Unsigned restoring divide, one quotient bit per clock; divide by zero returns all ones
`default_nettype none

module mant_divider #(
    parameter int DIV_W = 48
) (
    input  logic           clk_sys,
    input  logic           rst_sys_n,
    mant_div_if.divider    div
);

    localparam int CNT_W = $clog2(DIV_W + 1);

    logic             busy;
    logic             done_q;
    logic [CNT_W-1:0] bit_cnt;
    // Dividend bits leave at the top, quotient bits enter at the bottom
    logic [DIV_W-1:0] shift_q;
    logic [DIV_W-1:0] rem_q;
    logic [DIV_W-1:0] divisor_q;
    logic [DIV_W:0]   trial;
    logic [DIV_W+1:0] diff;
    logic             q_bit;

    // ------------------------------------------------------------------
    // Trial subtraction
    // ------------------------------------------------------------------
    always_comb begin
        // Partial remainder with the next dividend bit shifted in
        trial = {rem_q, shift_q[DIV_W-1]};
        diff  = {1'b0, trial} - {2'b00, divisor_q};
        // No borrow means the divisor fits
        q_bit = ~diff[DIV_W+1];
    end

    // ------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            busy    <= 1'b0;
            done_q  <= 1'b0;
            bit_cnt <= '0;
        end else begin
            done_q <= 1'b0;
            if (!busy) begin
                if (div.start) begin
                    busy    <= 1'b1;
                    bit_cnt <= '0;
                end
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
                // Last quotient bit this cycle
                if (bit_cnt == CNT_W'(DIV_W - 1)) begin
                    busy   <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk_sys) begin
        if (!busy && div.start) begin
            shift_q   <= div.dividend;
            divisor_q <= div.divisor;
            rem_q     <= '0;
        end else if (busy) begin
            shift_q <= {shift_q[DIV_W-2:0], q_bit};
            // Restore on borrow, keep the difference otherwise
            rem_q   <= q_bit ? diff[DIV_W-1:0] : trial[DIV_W-1:0];
        end
    end

    assign div.quotient = shift_q;
    assign div.done     = done_q;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the float divide testbench with Verilator, then scan the log for failure
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --assert -Wno-fatal -f build.f --top-module float_div_tb \
    -o float_div_sim > build.log 2>&1 \
    && ./obj_dir/float_div_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -q "TESTBENCH FAILED" sim.log \
    && { echo "Simulation reported failure"; exit 1; } \
    || { echo "Simulation reported no failure"; exit 0; }
